/* Bender.yml */
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - wb_pkg.sv
  - mem1_stage.sv
  - dbus_master.sv
  - mem2_stage.sv
  - lsu_top.sv
  - target: test
    files:
      - wb_mem_model.sv
      - lsu_asserts.sv
      - tb_lsu.sv

/* dbus_master.sv */
`timescale 1ns/10ps

module dbus_master (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         access_req_i,
    input  lsu_pkg::mem1_mem2_t          access_i,
    input  wb_pkg::wb_s2m_t              wb_i,
    output wb_pkg::wb_m2s_t              wb_o,
    output logic                         data_ok_o,
    output logic [lsu_pkg::XLEN-1:0]     rdata_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUS,
        S_RELEASE
    } state_e;

    state_e                        state_q;
    logic                          start;
    logic                          abandon_q;
    logic                          we_q;
    logic [wb_pkg::WB_ADR_W-1:0]   adr_q;
    logic [wb_pkg::WB_SEL_W-1:0]   sel_q;
    logic [wb_pkg::WB_DAT_W-1:0]   dat_q;

    // in release the request seen is always a new one, the old record has moved on
    assign start = access_req_i & ((state_q == S_IDLE) | (state_q == S_RELEASE));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE:    if (start) state_q <= S_BUS;
                S_BUS:     if (wb_i.ack) state_q <= S_RELEASE;
                S_RELEASE: state_q <= start ? S_BUS : S_IDLE;
                default:   state_q <= S_IDLE;
            endcase
        end
    end

    // once the requester lets go mid cycle (flush) the reply belongs to nobody
    always_ff @(posedge clk) begin
        if (rst) begin
            abandon_q <= 1'b0;
        end else if (start) begin
            abandon_q <= 1'b0;
        end else if ((state_q == S_BUS) & ~access_req_i) begin
            abandon_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            we_q  <= access_i.is_store;
            adr_q <= {access_i.addr[wb_pkg::WB_ADR_W-1:2], 2'b00};  // word address
            sel_q <= access_i.byte_sel;
            dat_q <= access_i.st_data;
        end
    end

    always_comb begin
        wb_o.cyc   = (state_q == S_BUS);
        wb_o.stb   = (state_q == S_BUS);
        wb_o.we    = we_q;
        wb_o.adr   = adr_q;
        wb_o.sel   = sel_q;
        wb_o.dat_w = dat_q;
    end

    assign data_ok_o = (state_q == S_BUS) & wb_i.ack & access_req_i & ~abandon_q;
    assign rdata_o   = wb_i.dat_r;

endmodule

/* lsu_asserts.sv */
`timescale 1ns/10ps

module lsu_asserts (
    input logic                clk,
    input logic                rst,
    input wb_pkg::wb_m2s_t     wb_o,
    input wb_pkg::wb_s2m_t     wb_i,
    input logic                advance_o,
    input lsu_pkg::mem1_mem2_t mem1_q
);

    int fail_cnt = 0;

    stb_with_cyc: assert property (@(posedge clk) disable iff (rst) wb_o.stb |-> wb_o.cyc)
        else begin fail_cnt++; $error("stb high without cyc"); end

    // request fields and the cycle itself hold until the slave acks
    hold_until_ack: assert property (@(posedge clk) disable iff (rst)
        (wb_o.cyc && !wb_i.ack) |=> (wb_o.cyc && $stable(wb_o.adr) && $stable(wb_o.we)
                                     && $stable(wb_o.sel) && $stable(wb_o.dat_w)))
        else begin fail_cnt++; $error("wishbone request changed before ack"); end

    adv_after_reset: assert property (@(posedge clk) rst |=> advance_o)
        else begin fail_cnt++; $error("advance low after reset"); end

    no_cycle_on_ale: assert property (@(posedge clk) disable iff (rst)
        mem1_q.ale |=> !$rose(wb_o.cyc))
        else begin fail_cnt++; $error("bus cycle started for misaligned access"); end

endmodule

bind lsu_top lsu_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .wb_o      (wb_o),
    .wb_i      (wb_i),
    .advance_o (advance_o),
    .mem1_q    (mem1_q)
);

/* lsu_pkg.sv */
package lsu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int BSEL_W     = XLEN / 8;  // one select bit per byte lane

    typedef enum logic [3:0] {
        NONE  = 4'd0,
        LD_B  = 4'd1,
        LD_BU = 4'd2,
        LD_H  = 4'd3,
        LD_HU = 4'd4,
        LD_W  = 4'd5,
        ST_B  = 4'd6,
        ST_H  = 4'd7,
        ST_W  = 4'd8
    } mem_op_e;

    // what execute hands over, wdata is the alu result for non-memory ops
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        mem_op_e               op;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       st_data;
        logic                  wreg;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } ex_mem1_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        mem_op_e               op;
        logic [XLEN-1:0]       addr;
        logic                  mem_access_valid;  // a bus cycle is needed
        logic                  is_store;
        logic [BSEL_W-1:0]     byte_sel;
        logic [XLEN-1:0]       st_data;           // already replicated onto the lanes
        logic                  wreg;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        logic                  ale;
    } mem1_mem2_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic                  wreg;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        logic                  ale;
    } mem2_wb_t;

    typedef struct packed {
        logic                  wreg;
        logic                  data_ready;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } data_forward_t;

endpackage

/* lsu_top.sv */
`timescale 1ns/10ps

module lsu_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  lsu_pkg::ex_mem1_t       req_i,
    input  wb_pkg::wb_s2m_t         wb_i,
    output logic                    advance_o,
    output wb_pkg::wb_m2s_t         wb_o,
    output lsu_pkg::data_forward_t  fwd_o,
    output lsu_pkg::mem2_wb_t       result_o
);

    lsu_pkg::mem1_mem2_t          mem1_q;
    logic                         access_req;
    logic                         data_ok;
    logic [lsu_pkg::XLEN-1:0]     rdata;

    mem1_stage u_mem1 (
        .clk       (clk),
        .rst       (rst),
        .flush_i   (flush_i),
        .advance_i (advance_o),
        .req_i     (req_i),
        .mem1_o    (mem1_q)
    );

    dbus_master u_dbus (
        .clk          (clk),
        .rst          (rst),
        .access_req_i (access_req),
        .access_i     (mem1_q),
        .wb_i         (wb_i),
        .wb_o         (wb_o),
        .data_ok_o    (data_ok),
        .rdata_o      (rdata)
    );

    // mem2 alone decides when the whole back end moves
    mem2_stage u_mem2 (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (flush_i),
        .mem1_i          (mem1_q),
        .data_ok_i       (data_ok),
        .rdata_i         (rdata),
        .access_req_o    (access_req),
        .advance_ready_o (advance_o),
        .fwd_o           (fwd_o),
        .result_o        (result_o)
    );

endmodule

/* mem1_stage.sv */
`timescale 1ns/10ps

module mem1_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush_i,
    input  logic                advance_i,
    input  lsu_pkg::ex_mem1_t   req_i,
    output lsu_pkg::mem1_mem2_t mem1_o
);

    logic                         is_load;
    logic                         is_store;
    logic [1:0]                   size;        // 0 byte, 1 halfword, 2 word
    logic                         misaligned;
    logic                         ale;
    logic [lsu_pkg::BSEL_W-1:0]   byte_sel;
    logic [lsu_pkg::XLEN-1:0]     st_data;
    lsu_pkg::mem1_mem2_t          mem1_d;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        size     = 2'd0;
        case (req_i.op)
            lsu_pkg::LD_B, lsu_pkg::LD_BU: is_load = 1'b1;
            lsu_pkg::LD_H, lsu_pkg::LD_HU: begin
                is_load = 1'b1;
                size    = 2'd1;
            end
            lsu_pkg::LD_W: begin
                is_load = 1'b1;
                size    = 2'd2;
            end
            lsu_pkg::ST_B: is_store = 1'b1;
            lsu_pkg::ST_H: begin
                is_store = 1'b1;
                size     = 2'd1;
            end
            lsu_pkg::ST_W: begin
                is_store = 1'b1;
                size     = 2'd2;
            end
            default: ;
        endcase
    end

    assign misaligned = ((size == 2'd1) & req_i.addr[0]) |
                        ((size == 2'd2) & (|req_i.addr[1:0]));
    assign ale = req_i.valid & (is_load | is_store) & misaligned;

    // loads carry the lane select too, the slave may use it for reads
    always_comb begin
        case (size)
            2'd0:    byte_sel = 4'b0001 << req_i.addr[1:0];
            2'd1:    byte_sel = req_i.addr[1] ? 4'b1100 : 4'b0011;
            default: byte_sel = 4'b1111;
        endcase
    end

    always_comb begin
        case (size)
            2'd0:    st_data = {4{req_i.st_data[7:0]}};
            2'd1:    st_data = {2{req_i.st_data[15:0]}};
            default: st_data = req_i.st_data;
        endcase
    end

    always_comb begin
        mem1_d.valid            = req_i.valid;
        mem1_d.pc               = req_i.pc;
        mem1_d.op               = req_i.op;
        mem1_d.addr             = req_i.addr;
        mem1_d.mem_access_valid = req_i.valid & (is_load | is_store) & ~ale;
        mem1_d.is_store         = is_store;
        mem1_d.byte_sel         = byte_sel;
        mem1_d.st_data          = st_data;
        mem1_d.wreg             = req_i.wreg;
        mem1_d.waddr            = req_i.waddr;
        mem1_d.wdata            = req_i.wdata;
        mem1_d.ale              = ale;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem1_o <= '0;
        end else if (flush_i) begin
            mem1_o <= '0;
        end else if (advance_i) begin
            mem1_o <= mem1_d;
        end
    end

endmodule

/* mem2_stage.sv */
`timescale 1ns/10ps

module mem2_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush_i,
    input  lsu_pkg::mem1_mem2_t          mem1_i,
    input  logic                         data_ok_i,
    input  logic [lsu_pkg::XLEN-1:0]     rdata_i,
    output logic                         access_req_o,
    output logic                         advance_ready_o,
    output lsu_pkg::data_forward_t       fwd_o,
    output lsu_pkg::mem2_wb_t            result_o
);

    localparam int XLEN = lsu_pkg::XLEN;

    logic                 mem_access;
    logic                 is_load;
    logic                 reply_ok;
    logic                 advance;
    logic                 data_already_ok;
    logic [XLEN-1:0]      data_delay;
    logic [XLEN-1:0]      load_data;
    logic [XLEN-1:0]      lane;
    lsu_pkg::mem2_wb_t    wb_d;

    assign mem_access = mem1_i.mem_access_valid;
    assign is_load    = mem_access & ~mem1_i.is_store;
    assign reply_ok   = data_ok_i | data_already_ok;

    // stores wait for their ack as well as loads
    assign advance         = ~mem_access | reply_ok;
    assign advance_ready_o = advance;
    assign access_req_o    = mem_access & ~data_already_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_already_ok <= 1'b0;
        end else if (advance | flush_i) begin
            data_already_ok <= 1'b0;
        end else if (data_ok_i) begin
            data_already_ok <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_ok_i) data_delay <= rdata_i;
    end

    assign load_data = data_already_ok ? data_delay : rdata_i;
    assign lane      = load_data >> {mem1_i.addr[1:0], 3'b000};  // addressed byte to bit 0

    always_comb begin
        wb_d.valid = mem1_i.valid;
        wb_d.pc    = mem1_i.pc;
        wb_d.wreg  = mem1_i.wreg;
        wb_d.waddr = mem1_i.waddr;
        wb_d.wdata = mem1_i.wdata;
        wb_d.ale   = mem1_i.ale;
        if (is_load) begin
            case (mem1_i.op)
                lsu_pkg::LD_B:  wb_d.wdata = {{(XLEN-8){lane[7]}}, lane[7:0]};
                lsu_pkg::LD_BU: wb_d.wdata = {{(XLEN-8){1'b0}}, lane[7:0]};
                lsu_pkg::LD_H:  wb_d.wdata = {{(XLEN-16){lane[15]}}, lane[15:0]};
                lsu_pkg::LD_HU: wb_d.wdata = {{(XLEN-16){1'b0}}, lane[15:0]};
                lsu_pkg::LD_W:  wb_d.wdata = load_data;
                default: ;
            endcase
        end
    end

    // a load is only forwardable once its data is here
    always_comb begin
        fwd_o.wreg       = mem1_i.wreg;
        fwd_o.data_ready = ~is_load | reply_ok;
        fwd_o.waddr      = mem1_i.waddr;
        fwd_o.wdata      = wb_d.wdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_o <= '0;
        end else if (flush_i) begin
            result_o <= '0;
        end else if (advance) begin
            result_o <= wb_d;
        end
    end

endmodule

/* tb_lsu.sv */
`timescale 1ns/10ps

module tb_lsu;

    localparam int N_OPS    = 110;
    localparam int LAT_CYC  = 8;     // three wait states plus the pipeline and release
    localparam int TIMEOUT  = (N_OPS * LAT_CYC + 200) * 20;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   flush;
    lsu_pkg::ex_mem1_t      req;
    wb_pkg::wb_s2m_t        wb_s2m;
    wb_pkg::wb_m2s_t        wb_m2s;
    logic                   advance;
    lsu_pkg::data_forward_t fwd;
    lsu_pkg::mem2_wb_t      result;

    lsu_pkg::mem2_wb_t exp_q [$];
    lsu_pkg::mem2_wb_t got_q [$];
    logic [31:0]       shadow [0:255];
    logic [31:0]       next_pc = 32'h1000;
    int                seed = 22;
    int                checks = 0;
    int                errors = 0;
    int                bus_cycles = 0;
    logic              loaded = 1'b0;
    logic              cyc_prev = 1'b0;
    logic              adv_check = 1'b0;

    lsu_top UUT (
        .clk      (clk),
        .rst      (rst),
        .flush_i  (flush),
        .req_i    (req),
        .wb_i     (wb_s2m),
        .advance_o(advance),
        .wb_o     (wb_m2s),
        .fwd_o    (fwd),
        .result_o (result)
    );

    wb_mem_model u_mem (.clk(clk), .rst(rst), .wb_i(wb_m2s), .wb_o(wb_s2m));

    always #10 clk = ~clk;

    function automatic logic [31:0] fill_word(input int i);
        return (i * 32'h0100_0193) ^ 32'h8c3a_e5d1;
    endfunction

    // a result is new only if the result register loaded at the edge before
    always @(negedge clk) begin
        if (!rst && loaded && result.valid) got_q.push_back(result);
        loaded = advance;
        if (wb_m2s.cyc && !cyc_prev) bus_cycles++;
        cyc_prev = wb_m2s.cyc;
        if (adv_check && wb_m2s.cyc && !wb_s2m.ack) begin
            assert (!advance) else begin
                errors++;
                $display("advance high while a bus reply is outstanding");
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: run exceeded %0d ns", TIMEOUT);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic lsu_pkg::ex_mem1_t mk(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                                             input logic [31:0] st, input logic [31:0] wdata);
        lsu_pkg::ex_mem1_t r;
        r.valid   = 1'b1;
        r.pc      = next_pc;
        r.op      = op;
        r.addr    = addr;
        r.st_data = st;
        r.wreg    = (op < lsu_pkg::ST_B);
        r.waddr   = next_pc[6:2];
        r.wdata   = wdata;
        next_pc   = next_pc + 32'd4;
        return r;
    endfunction

    // expected writeback record, stores update the shadow memory in issue order
    function automatic lsu_pkg::mem2_wb_t expect_for(input lsu_pkg::ex_mem1_t r);
        lsu_pkg::mem2_wb_t e;
        logic [31:0]       w;
        logic [31:0]       b;
        logic              mis;
        e.valid = 1'b1;
        e.pc    = r.pc;
        e.wreg  = r.wreg;
        e.waddr = r.waddr;
        e.wdata = r.wdata;
        mis = ((r.op inside {lsu_pkg::LD_H, lsu_pkg::LD_HU, lsu_pkg::ST_H}) && r.addr[0]) ||
              ((r.op inside {lsu_pkg::LD_W, lsu_pkg::ST_W}) && (r.addr[1:0] != 2'd0));
        e.ale = mis;
        if (!mis) begin
            w = shadow[r.addr[9:2]];
            b = w >> (r.addr[1:0] * 8);
            case (r.op)
                lsu_pkg::LD_B:  e.wdata = {{24{b[7]}}, b[7:0]};
                lsu_pkg::LD_BU: e.wdata = {24'd0, b[7:0]};
                lsu_pkg::LD_H:  e.wdata = {{16{b[15]}}, b[15:0]};
                lsu_pkg::LD_HU: e.wdata = {16'd0, b[15:0]};
                lsu_pkg::LD_W:  e.wdata = w;
                lsu_pkg::ST_B:  w[8*r.addr[1:0] +: 8] = r.st_data[7:0];
                lsu_pkg::ST_H:  w[16*r.addr[1] +: 16] = r.st_data[15:0];
                lsu_pkg::ST_W:  w = r.st_data;
                default: ;
            endcase
            shadow[r.addr[9:2]] = w;
        end
        return e;
    endfunction

    // present a record and hold it until the stage can take it at the next edge
    task automatic send(input lsu_pkg::ex_mem1_t r);
        @(posedge clk);
        req <= r;
        exp_q.push_back(expect_for(r));
        do @(negedge clk); while (!advance);
    endtask

    task automatic idle();
        @(posedge clk);
        req <= '0;
    endtask

    task automatic drain();
        lsu_pkg::mem2_wb_t g;
        lsu_pkg::mem2_wb_t e;
        while (got_q.size() < exp_q.size()) @(negedge clk);
        while (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            g = got_q.pop_front();
            check_val("result_o.pc", g.pc, e.pc);
            check_val("result_o.wdata", g.wdata, e.wdata);
            check_val("result_o.ale", g.ale, e.ale);
            check_val("result_o.wreg", g.wreg, e.wreg);
            check_val("result_o.waddr", g.waddr, e.waddr);
        end
        repeat (6) @(negedge clk);
        checks++;
        assert (got_q.size() == 0) else begin
            errors++;
            $display("a completion appeared more than once or without a request");
            got_q.delete();
        end
    endtask

    task automatic report(input string name, input int err_before);
        $display("test %s done, %0d errors", name, errors - err_before);
    endtask

    task automatic loads_all_offsets();
        int e0 = errors;
        logic [31:0] a;
        for (int w = 0; w < 4; w++) begin
            a = 32'h40 + w * 4;
            for (int o = 0; o < 4; o++) begin
                send(mk(lsu_pkg::LD_B, a + o, 0, 0));
                send(mk(lsu_pkg::LD_BU, a + o, 0, 0));
            end
            for (int o = 0; o < 4; o += 2) begin
                send(mk(lsu_pkg::LD_H, a + o, 0, 0));
                send(mk(lsu_pkg::LD_HU, a + o, 0, 0));
            end
            send(mk(lsu_pkg::LD_W, a, 0, 0));
        end
        idle();
        drain();
        report("loads", e0);
    endtask

    task automatic store_lane_merge();
        int e0 = errors;
        send(mk(lsu_pkg::ST_B, 32'h101, 32'h0000_00a7, 0));
        send(mk(lsu_pkg::ST_B, 32'h103, 32'h0000_0039, 0));
        send(mk(lsu_pkg::LD_W, 32'h100, 0, 0));
        send(mk(lsu_pkg::ST_H, 32'h106, 32'h0000_beef, 0));
        send(mk(lsu_pkg::ST_H, 32'h108, 32'h0000_8001, 0));
        send(mk(lsu_pkg::LD_W, 32'h104, 0, 0));
        send(mk(lsu_pkg::LD_W, 32'h108, 0, 0));
        idle();
        drain();
        report("stores", e0);
    endtask

    task automatic random_traffic();
        int e0 = errors;
        int sel;
        logic [31:0] a;
        lsu_pkg::mem_op_e ops [8];
        ops = '{lsu_pkg::LD_B, lsu_pkg::LD_BU, lsu_pkg::LD_H, lsu_pkg::LD_HU,
                lsu_pkg::LD_W, lsu_pkg::ST_B, lsu_pkg::ST_H, lsu_pkg::ST_W};
        adv_check = 1'b1;
        for (int i = 0; i < 40; i++) begin
            sel = ($random(seed) & 32'h7);
            a   = 32'h200 + ($random(seed) & 32'h1f);
            if (ops[sel] inside {lsu_pkg::LD_H, lsu_pkg::LD_HU, lsu_pkg::ST_H}) a[0] = 1'b0;
            if (ops[sel] inside {lsu_pkg::LD_W, lsu_pkg::ST_W}) a[1:0] = 2'b00;
            send(mk(ops[sel], a, $random(seed), 0));
        end
        idle();
        drain();
        adv_check = 1'b0;
        report("random_mix", e0);
    endtask

    task automatic misaligned_no_cycle();
        int e0 = errors;
        int cyc0 = bus_cycles;
        send(mk(lsu_pkg::LD_H, 32'h301, 0, 32'h1111_2222));
        send(mk(lsu_pkg::LD_W, 32'h302, 0, 32'h3333_4444));
        send(mk(lsu_pkg::ST_W, 32'h305, 32'hdead_beef, 0));
        send(mk(lsu_pkg::ST_H, 32'h30b, 32'hcafe, 0));
        idle();
        drain();
        check_val("bus cycle count", bus_cycles, cyc0);
        report("misaligned", e0);
    endtask

    task automatic forward_timing();
        int e0 = errors;
        lsu_pkg::mem2_wb_t e;
        send(mk(lsu_pkg::NONE, 0, 0, 32'h5a5a_0f0f));
        e = exp_q[exp_q.size()-1];
        idle();
        @(negedge clk);
        check_val("fwd_o.data_ready", fwd.data_ready, 1'b1);
        check_val("fwd_o.wreg", fwd.wreg, e.wreg);
        check_val("fwd_o.wdata", fwd.wdata, e.wdata);
        check_val("fwd_o.waddr", fwd.waddr, e.waddr);
        @(negedge clk);
        check_val("result_o.valid", result.valid, 1'b1);
        check_val("result_o.wdata", result.wdata, e.wdata);
        send(mk(lsu_pkg::LD_H, 32'h46, 0, 0));
        e = exp_q[exp_q.size()-1];
        idle();
        @(negedge clk);
        @(negedge clk);
        check_val("fwd_o.data_ready", fwd.data_ready, 1'b0);
        while (!fwd.data_ready) @(negedge clk);
        check_val("fwd_o.wdata", fwd.wdata, e.wdata);
        drain();
        report("forward", e0);
    endtask

    task automatic flush_pending_load();
        int e0 = errors;
        lsu_pkg::ex_mem1_t ld;
        ld = mk(lsu_pkg::LD_W, 32'h80, 0, 0);
        @(posedge clk);
        req <= ld;
        do @(negedge clk); while (!advance);
        idle();
        do @(negedge clk); while (!wb_m2s.cyc);
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        do @(negedge clk); while (wb_m2s.cyc);
        send(mk(lsu_pkg::NONE, 0, 0, 32'h0bad_f00d));
        send(mk(lsu_pkg::LD_W, 32'h84, 0, 0));
        idle();
        drain();
        report("flush", e0);
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            u_mem.mem[i] <= fill_word(i);
            shadow[i]    = fill_word(i);
        end
        rst   = 1'b1;
        flush = 1'b0;
        req   = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        loads_all_offsets();
        store_lane_merge();
        random_traffic();
        misaligned_no_cycle();
        forward_timing();
        flush_pending_load();
        repeat (2) @(posedge clk);
        errors = errors + UUT.u_asserts.fail_cnt;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
lsu_pkg.sv
wb_pkg.sv
mem1_stage.sv
dbus_master.sv
mem2_stage.sv
lsu_top.sv
wb_mem_model.sv
lsu_asserts.sv
tb_lsu.sv

/* wb_mem_model.sv */
`timescale 1ns/10ps

module wb_mem_model (
    input  logic            clk,
    input  logic            rst,
    input  wb_pkg::wb_m2s_t wb_i,
    output wb_pkg::wb_s2m_t wb_o
);

    localparam int DEPTH = 256;

    // filled by the testbench before reset is released
    logic [wb_pkg::WB_DAT_W-1:0] mem [0:DEPTH-1];

    int                          seed = 22;
    logic [1:0]                  wait_left;
    logic                        ack_q;
    logic [wb_pkg::WB_DAT_W-1:0] dat_q;
    logic [7:0]                  idx;

    assign idx = wb_i.adr[9:2];

    always @(posedge clk) begin
        if (rst) begin
            ack_q     <= 1'b0;
            wait_left <= 2'($random(seed));
            dat_q     <= '0;
        end else if (ack_q) begin
            ack_q     <= 1'b0;
            wait_left <= 2'($random(seed));  // wait states for the next cycle
        end else if (wb_i.cyc & wb_i.stb) begin
            if (wait_left == 2'd0) begin
                ack_q <= 1'b1;
                dat_q <= mem[idx];
                if (wb_i.we) begin
                    for (int i = 0; i < wb_pkg::WB_SEL_W; i++) begin
                        if (wb_i.sel[i]) mem[idx][8*i +: 8] <= wb_i.dat_w[8*i +: 8];
                    end
                end
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    assign wb_o.ack   = ack_q;
    assign wb_o.dat_r = dat_q;

endmodule

/* wb_pkg.sv */
package wb_pkg;

    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;

    // classic cycle, stb is only meaningful while cyc is high
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_SEL_W-1:0] sel;
        logic [WB_DAT_W-1:0] dat_w;
    } wb_m2s_t;

    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat_r;
    } wb_s2m_t;

endpackage
